//--- project.f
+incdir+verilog
verilog/types_pkg.sv
verilog/skid_buffer_struct.sv
verilog/ready_table.sv
verilog/rs.sv
verilog/dispatch.sv
verilog/dispatch_core.sv
verif/dispatch_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dispatch_tb
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

//--- verif/dispatch_tb.sv
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatch_tb;
    import types_pkg::*;

    localparam int T_RAND  = 2000;
    localparam int T_BP    = 390;
    localparam int T_FLUSH = 800;
    localparam int T_DRAIN = 150;
    localparam int LIMIT   = 4 + T_RAND + T_BP + T_FLUSH + T_DRAIN + 200;

    logic       clk = 1'b0;
    logic       reset;
    logic       valid_in;
    rename_data data_in;
    logic       ready_in;
    logic       alu_rs_valid;
    rs_data     alu_rs_data;
    logic       br_rs_valid;
    rs_data     br_rs_data;
    logic       lsu_rs_valid;
    rs_data     lsu_rs_data;
    logic [2:0] fu_rdy;
    cdb_t       cdb_a;
    cdb_t       cdb_b;
    cdb_t       cdb_c;
    rob_alloc_t rob_alloc;
    logic [`ROB_TAG_W-1:0] rob_tag;
    logic       rob_full;
    logic       mispredict;

    integer seed = 32'he402_db44;
    int     errors;
    int     checks;
    int     cycles;

    // Reference model state
    logic                  busy_m   [`PREG_COUNT];
    logic                  free_reg [`PREG_COUNT];
    int                    src_use  [`PREG_COUNT];
    logic [`PREG_W-1:0]    busy_q [$];
    rename_data            buf_q [3][$];
    dispatch_pipeline_data st_q  [3][$];
    rename_data            pend;
    logic                  have_pending;

    // Traffic knobs
    int valid_pct;
    int full_pct;
    int cdb_pct;
    int fu_pct;
    int mp_rate;
    int hold_class;

    dispatch_core dut_i (
        .clk(clk),
        .reset(reset),
        .valid_in(valid_in),
        .data_in(data_in),
        .ready_in(ready_in),
        .alu_rs_valid(alu_rs_valid),
        .alu_rs_data(alu_rs_data),
        .alu_rs_ready(fu_rdy[0]),
        .br_rs_valid(br_rs_valid),
        .br_rs_data(br_rs_data),
        .br_rs_ready(fu_rdy[1]),
        .lsu_rs_valid(lsu_rs_valid),
        .lsu_rs_data(lsu_rs_data),
        .lsu_rs_ready(fu_rdy[2]),
        .cdb_a(cdb_a),
        .cdb_b(cdb_b),
        .cdb_c(cdb_c),
        .rob_alloc(rob_alloc),
        .rob_tag(rob_tag),
        .rob_full(rob_full),
        .mispredict(mispredict)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run still going after %0d cycles", LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic int rnd(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    task automatic check_rs_data(input rs_data got, input rs_data exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t: issued packet %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_alloc(input rob_alloc_t got, input rob_alloc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t: rob_alloc %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_bit(input string label, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t: %s is %b, expected %b", $time, label, got, exp);
        end
    endtask

    function automatic logic cdb_hit(input logic [`PREG_W-1:0] tag);
        return (cdb_a.valid && cdb_a.preg == tag) ||
               (cdb_b.valid && cdb_b.preg == tag) ||
               (cdb_c.valid && cdb_c.preg == tag);
    endfunction

    function automatic int class_index(input fu_class_t f);
        if (f.alu) begin
            return 0;
        end
        return f.br ? 1 : 2;
    endfunction

    function automatic logic port_valid(input int c);
        case (c)
            0: return alu_rs_valid;
            1: return br_rs_valid;
            default: return lsu_rs_valid;
        endcase
    endfunction

    function automatic rs_data port_data(input int c);
        case (c)
            0: return alu_rs_data;
            1: return br_rs_data;
            default: return lsu_rs_data;
        endcase
    endfunction

    // Station entry as dispatch should build it
    function automatic dispatch_pipeline_data make_entry(input rename_data r,
                                                         input logic [`ROB_TAG_W-1:0] tag);
        dispatch_pipeline_data e;
        e.opcode    = r.opcode;
        e.func3     = r.func3;
        e.func7     = r.func7;
        e.pc        = r.pc;
        e.imm       = r.imm;
        e.prd       = r.pd_new;
        e.pr1       = r.ps1;
        e.pr2       = r.ps2;
        e.pr1_ready = (r.ps1 == '0) || !busy_m[r.ps1] || cdb_hit(r.ps1);
        e.pr2_ready = (r.ps2 == '0) || !busy_m[r.ps2] || cdb_hit(r.ps2);
        e.rob_index = tag;
        return e;
    endfunction

    function automatic rs_data to_issue(input dispatch_pipeline_data e);
        rs_data d;
        d.opcode    = e.opcode;
        d.func3     = e.func3;
        d.func7     = e.func7;
        d.pc        = e.pc;
        d.imm       = e.imm;
        d.prd       = e.prd;
        d.pr1       = e.pr1;
        d.pr2       = e.pr2;
        d.rob_index = e.rob_index;
        return d;
    endfunction

    task automatic release_src(input logic [`PREG_W-1:0] p);
        if (p != '0) begin
            src_use[p]--;
        end
    endtask

    // Source is x0, an in-flight destination or a ready register
    task automatic pick_src(output logic [`PREG_W-1:0] p);
        int kind;
        int r;
        kind = rnd(4);
        p = '0;
        if ((kind == 1 || kind == 2) && busy_q.size() > 0) begin
            p = busy_q[rnd(busy_q.size())];
        end else if (kind == 3) begin
            r = 1 + rnd(`PREG_COUNT - 1);
            if (free_reg[r]) begin
                p = `PREG_W'(r);
            end
        end
        if (p != '0) begin
            src_use[p]++;
        end
    endtask

    task automatic gen_instr();
        int k;
        int r;
        logic [`PREG_W-1:0] d;
        d = '0;
        for (int t = 0; t < 20; t++) begin
            r = 1 + rnd(`PREG_COUNT - 1);
            if (d == '0 && free_reg[r] && src_use[r] == 0) begin
                d = `PREG_W'(r);
            end
        end
        if (d != '0) begin
            free_reg[d] = 1'b0;
            k = rnd(3);
            pend.opcode = 7'(rnd(128));
            pend.func3  = 3'(rnd(8));
            pend.func7  = 7'(rnd(128));
            pend.pc     = $random(seed);
            pend.imm    = $random(seed);
            pick_src(pend.ps1);
            pick_src(pend.ps2);
            pend.pd_new = d;
            pend.pd_old = `PREG_W'(rnd(`PREG_COUNT));
            pend.fu     = fu_class_t'(3'(1 << k));
            have_pending = 1'b1;
        end
    endtask

    task automatic drive_inputs();
        logic mp;
        cdb_t b [3];
        mp = (mp_rate > 0) && (rnd(mp_rate) == 0);
        for (int k = 0; k < 3; k++) begin
            b[k] = '0;
            if (busy_q.size() > 0 && rnd(100) < cdb_pct) begin
                b[k].valid = 1'b1;
                b[k].preg  = busy_q.pop_front();
            end
        end
        cdb_a = b[0];
        cdb_b = b[1];
        cdb_c = b[2];
        for (int c = 0; c < 3; c++) begin
            fu_rdy[c] = !mp && (c != hold_class) && (rnd(100) < fu_pct);
        end
        mispredict = mp;
        rob_full   = rnd(100) < full_pct;
        rob_tag    = `ROB_TAG_W'(rnd(32));
        if (!have_pending && rnd(100) < valid_pct) begin
            gen_instr();
        end
        // Held until accepted
        valid_in = have_pending && !mp;
        data_in  = pend;
    endtask

    task automatic apply_cdb(input cdb_t x);
        if (x.valid) begin
            busy_m[x.preg]   = 1'b0;
            free_reg[x.preg] = 1'b1;
        end
    endtask

    task automatic flush_model();
        for (int c = 0; c < 3; c++) begin
            buf_q[c].delete();
            st_q[c].delete();
        end
        for (int r = 0; r < `PREG_COUNT; r++) begin
            src_use[r] = 0;
        end
        if (have_pending) begin
            if (pend.ps1 != '0) begin
                src_use[pend.ps1]++;
            end
            if (pend.ps2 != '0) begin
                src_use[pend.ps2]++;
            end
        end
    endtask

    // Called between edges, inputs and outputs stable
    task automatic model_step();
        int d;
        int idx;
        int cls;
        int cnt_before [3];
        rename_data r;
        rob_alloc_t ea;
        dispatch_pipeline_data e;
        d = -1;
        for (int c = 2; c >= 0; c--) begin
            if (buf_q[c].size() > 0 && st_q[c].size() < `RS_DEPTH &&
                !rob_full && !mispredict) begin
                d = c;
            end
            cnt_before[c] = buf_q[c].size();
        end

        // Each skid buffer takes a new packet unless both slots hold data
        check_bit("ready_in", ready_in,
                  cnt_before[0] < 2 && cnt_before[1] < 2 && cnt_before[2] < 2);

        check_bit("rob_alloc.we", rob_alloc.we, d >= 0);
        if (d >= 0) begin
            r = buf_q[d][0];
            ea.we     = 1'b1;
            ea.pd_new = r.pd_new;
            ea.pd_old = r.pd_old;
            ea.pc     = r.pc;
            check_alloc(rob_alloc, ea);
        end

        // Oldest entry whose sources are both ready
        for (int c = 0; c < 3; c++) begin
            idx = -1;
            for (int i = 0; i < st_q[c].size(); i++) begin
                if (idx < 0 && st_q[c][i].pr1_ready && st_q[c][i].pr2_ready) begin
                    idx = i;
                end
            end
            check_bit($sformatf("issue valid %0d", c), port_valid(c), idx >= 0);
            if (idx >= 0 && port_valid(c) && fu_rdy[c]) begin
                e = st_q[c][idx];
                check_rs_data(port_data(c), to_issue(e));
                release_src(e.pr1);
                release_src(e.pr2);
                st_q[c].delete(idx);
            end
        end

        for (int c = 0; c < 3; c++) begin
            for (int i = 0; i < st_q[c].size(); i++) begin
                e = st_q[c][i];
                if (cdb_hit(e.pr1)) begin
                    e.pr1_ready = 1'b1;
                end
                if (cdb_hit(e.pr2)) begin
                    e.pr2_ready = 1'b1;
                end
                st_q[c][i] = e;
            end
        end

        if (d >= 0) begin
            r = buf_q[d].pop_front();
            st_q[d].push_back(make_entry(r, rob_tag));
        end

        if (valid_in && ready_in) begin
            cls = class_index(data_in.fu);
            if (cnt_before[cls] > 1) begin
                errors++;
                $display("FAIL t=%0t: accepted into a full skid buffer", $time);
            end
            buf_q[cls].push_back(data_in);
            busy_m[data_in.pd_new] = 1'b1;
            busy_q.push_back(data_in.pd_new);
            have_pending = 1'b0;
            if (buf_q[cls].size() + st_q[cls].size() > `RS_DEPTH + 2) begin
                errors++;
                $display("FAIL t=%0t: class %0d holds too many instructions", $time, cls);
            end
        end

        // Busy-set first so a broadcast wins
        apply_cdb(cdb_a);
        apply_cdb(cdb_b);
        apply_cdb(cdb_c);
        if (mispredict) begin
            flush_model();
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            model_step();
        end
    endtask

    function automatic int in_flight();
        return buf_q[0].size() + buf_q[1].size() + buf_q[2].size() +
               st_q[0].size() + st_q[1].size() + st_q[2].size();
    endfunction

    task automatic report_test(input string name, input int err_before);
        $display("test %-12s %s, %0d errors", name,
                 (errors == err_before) ? "ok" : "bad", errors - err_before);
    endtask

    initial begin
        int err_before;
        int n;
        reset      = 1'b1;
        valid_in   = 1'b0;
        data_in    = '0;
        fu_rdy     = '0;
        cdb_a      = '0;
        cdb_b      = '0;
        cdb_c      = '0;
        rob_tag    = '0;
        rob_full   = 1'b0;
        mispredict = 1'b0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        pend       = '0;
        have_pending = 1'b0;
        for (int r = 0; r < `PREG_COUNT; r++) begin
            busy_m[r]   = 1'b0;
            free_reg[r] = (r != 0);
            src_use[r]  = 0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_bit("ready_in in reset", ready_in, 1'b0);
        check_bit("rob_alloc.we in reset", rob_alloc.we, 1'b0);
        check_bit("alu valid in reset", alu_rs_valid, 1'b0);
        check_bit("br valid in reset", br_rs_valid, 1'b0);
        check_bit("lsu valid in reset", lsu_rs_valid, 1'b0);
        report_test("reset", 0);
        @(posedge clk);
        #1;
        reset = 1'b0;

        err_before = errors;
        valid_pct  = 70;
        full_pct   = 10;
        cdb_pct    = 60;
        fu_pct     = 75;
        mp_rate    = 0;
        hold_class = -1;
        run_cycles(T_RAND);
        report_test("random", err_before);

        // Each functional unit stalled in turn
        err_before = errors;
        for (int c = 0; c < 3; c++) begin
            hold_class = c;
            run_cycles(T_BP / 3);
        end
        hold_class = -1;
        report_test("backpressure", err_before);

        err_before = errors;
        mp_rate    = 40;
        run_cycles(T_FLUSH);
        mp_rate    = 0;
        report_test("flush", err_before);

        err_before = errors;
        valid_pct  = 0;
        full_pct   = 0;
        cdb_pct    = 100;
        fu_pct     = 100;
        n = 0;
        while (n < T_DRAIN && (in_flight() > 0 || busy_q.size() > 0)) begin
            run_cycles(1);
            n++;
        end
        if (in_flight() > 0) begin
            errors++;
            $display("drain did not finish: %0d instructions never issued", in_flight());
        end
        run_cycles(2);
        report_test("drain", err_before);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog/dispatch_core.sv
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatch_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid_in,
    input  types_pkg::rename_data data_in,
    output logic                  ready_in,
    output logic                  alu_rs_valid,
    output types_pkg::rs_data     alu_rs_data,
    input  logic                  alu_rs_ready,
    output logic                  br_rs_valid,
    output types_pkg::rs_data     br_rs_data,
    input  logic                  br_rs_ready,
    output logic                  lsu_rs_valid,
    output types_pkg::rs_data     lsu_rs_data,
    input  logic                  lsu_rs_ready,
    input  types_pkg::cdb_t       cdb_a,
    input  types_pkg::cdb_t       cdb_b,
    input  types_pkg::cdb_t       cdb_c,
    output types_pkg::rob_alloc_t rob_alloc,
    input  logic [`ROB_TAG_W-1:0] rob_tag,
    input  logic                  rob_full,
    input  logic                  mispredict
);

    logic [`PREG_W-1:0] query_ps1;
    logic [`PREG_W-1:0] query_ps2;
    logic               pr1_ready;
    logic               pr2_ready;
    logic               busy_valid;
    logic [`PREG_W-1:0] busy_preg;

    dispatch u_dispatch (
        .clk(clk),
        .reset(reset),
        .valid_in(valid_in),
        .data_in(data_in),
        .ready_in(ready_in),
        .alu_rs_valid(alu_rs_valid),
        .alu_rs_data(alu_rs_data),
        .alu_rs_ready(alu_rs_ready),
        .br_rs_valid(br_rs_valid),
        .br_rs_data(br_rs_data),
        .br_rs_ready(br_rs_ready),
        .lsu_rs_valid(lsu_rs_valid),
        .lsu_rs_data(lsu_rs_data),
        .lsu_rs_ready(lsu_rs_ready),
        .cdb_a(cdb_a),
        .cdb_b(cdb_b),
        .cdb_c(cdb_c),
        .query_ps1(query_ps1),
        .query_ps2(query_ps2),
        .pr1_ready(pr1_ready),
        .pr2_ready(pr2_ready),
        .busy_valid(busy_valid),
        .busy_preg(busy_preg),
        .rob_alloc(rob_alloc),
        .rob_tag(rob_tag),
        .rob_full(rob_full),
        .mispredict(mispredict)
    );

    // Busy at accept, ready at broadcast
    ready_table u_ready_table (
        .clk(clk),
        .reset(reset),
        .busy_valid(busy_valid),
        .busy_preg(busy_preg),
        .cdb_a(cdb_a),
        .cdb_b(cdb_b),
        .cdb_c(cdb_c),
        .query_ps1(query_ps1),
        .query_ps2(query_ps2),
        .pr1_ready(pr1_ready),
        .pr2_ready(pr2_ready)
    );

endmodule

//--- verilog/dispatch.sv
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatch (
    input  logic                  clk,
    input  logic                  reset,

    // Rename side
    input  logic                  valid_in,
    input  types_pkg::rename_data data_in,
    output logic                  ready_in,

    // Issue ports
    output logic                  alu_rs_valid,
    output types_pkg::rs_data     alu_rs_data,
    input  logic                  alu_rs_ready,
    output logic                  br_rs_valid,
    output types_pkg::rs_data     br_rs_data,
    input  logic                  br_rs_ready,
    output logic                  lsu_rs_valid,
    output types_pkg::rs_data     lsu_rs_data,
    input  logic                  lsu_rs_ready,

    // Result broadcasts
    input  types_pkg::cdb_t       cdb_a,
    input  types_pkg::cdb_t       cdb_b,
    input  types_pkg::cdb_t       cdb_c,

    // Ready table
    output logic [`PREG_W-1:0]    query_ps1,
    output logic [`PREG_W-1:0]    query_ps2,
    input  logic                  pr1_ready,
    input  logic                  pr2_ready,
    output logic                  busy_valid,
    output logic [`PREG_W-1:0]    busy_preg,

    // ROB
    output types_pkg::rob_alloc_t rob_alloc,
    input  logic [`ROB_TAG_W-1:0] rob_tag,
    input  logic                  rob_full,

    input  logic                  mispredict
);
    import types_pkg::*;

    localparam int N_CLASS = 3;
    localparam int C_ALU   = 0;
    localparam int C_BR    = 1;
    localparam int C_MEM   = 2;

    logic [N_CLASS-1:0]    class_sel;
    logic [N_CLASS-1:0]    buf_ready_in;
    logic [N_CLASS-1:0]    buf_valid;
    logic [N_CLASS-1:0]    buf_drain;
    rename_data            buf_data [N_CLASS];
    logic [N_CLASS-1:0]    rs_space;
    logic [N_CLASS-1:0]    eligible;
    logic [N_CLASS-1:0]    fu_ready;
    logic [N_CLASS-1:0]    iss_valid;
    rs_data                iss_data [N_CLASS];
    rename_data            active;
    dispatch_pipeline_data packet;
    logic                  accept;

    // Bit order matches the class indices
    assign class_sel = data_in.fu;
    assign fu_ready  = {lsu_rs_ready, br_rs_ready, alu_rs_ready};

    for (genvar c = 0; c < N_CLASS; c++) begin : g_class
        skid_buffer_struct #(.T(rename_data)) u_buf (
            .clk(clk),
            .reset(reset),
            .mispredict(mispredict),
            .valid_in(accept && class_sel[c]),
            .ready_in(buf_ready_in[c]),
            .data_in(data_in),
            .valid_out(buf_valid[c]),
            .ready_out(buf_drain[c]),
            .data_out(buf_data[c])
        );

        rs u_rs (
            .clk(clk),
            .reset(reset),
            .flush(mispredict),
            .valid_in(buf_drain[c]),
            .ready_in(rs_space[c]),
            .instr(packet),
            .cdb_a(cdb_a),
            .cdb_b(cdb_b),
            .cdb_c(cdb_c),
            .valid_out(iss_valid[c]),
            .data_out(iss_data[c]),
            .fu_rdy(fu_ready[c])
        );
    end

    // Same stall rule for every class
    assign ready_in = &buf_ready_in;
    assign accept   = valid_in && ready_in;

    assign busy_valid = accept && (data_in.pd_new != '0) && !mispredict;
    assign busy_preg  = data_in.pd_new;

    // One drain per cycle, alu first
    assign eligible = buf_valid & rs_space & {N_CLASS{!rob_full && !mispredict}};

    always_comb begin
        buf_drain = '0;
        active    = buf_data[C_ALU];
        for (int c = N_CLASS - 1; c >= 0; c--) begin
            if (eligible[c]) begin
                buf_drain    = '0;
                buf_drain[c] = 1'b1;
                active       = buf_data[c];
            end
        end
    end

    assign query_ps1 = active.ps1;
    assign query_ps2 = active.ps2;

    // Source readiness includes a same-cycle broadcast
    always_comb begin
        packet.opcode    = active.opcode;
        packet.func3     = active.func3;
        packet.func7     = active.func7;
        packet.pc        = active.pc;
        packet.imm       = active.imm;
        packet.prd       = active.pd_new;
        packet.pr1       = active.ps1;
        packet.pr2       = active.ps2;
        packet.pr1_ready = (active.ps1 == '0) || pr1_ready ||
                           cdb_match(active.ps1, cdb_a, cdb_b, cdb_c);
        packet.pr2_ready = (active.ps2 == '0) || pr2_ready ||
                           cdb_match(active.ps2, cdb_a, cdb_b, cdb_c);
        packet.rob_index = rob_tag;
    end

    always_comb begin
        rob_alloc.we     = |buf_drain;
        rob_alloc.pd_new = active.pd_new;
        rob_alloc.pd_old = active.pd_old;
        rob_alloc.pc     = active.pc;
    end

    assign alu_rs_valid = iss_valid[C_ALU];
    assign alu_rs_data  = iss_data[C_ALU];
    assign br_rs_valid  = iss_valid[C_BR];
    assign br_rs_data   = iss_data[C_BR];
    assign lsu_rs_valid = iss_valid[C_MEM];
    assign lsu_rs_data  = iss_data[C_MEM];

    // Rename sends exactly one class per packet
    a_one_class: assert property (
        @(posedge clk) disable iff (reset)
        valid_in |-> $onehot(data_in.fu)
    ) else $error("rename packet without a single class bit");

endmodule

//--- verilog/rs.sv
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module rs (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flush,
    input  logic                             valid_in,
    output logic                             ready_in,
    input  types_pkg::dispatch_pipeline_data instr,
    input  types_pkg::cdb_t                  cdb_a,
    input  types_pkg::cdb_t                  cdb_b,
    input  types_pkg::cdb_t                  cdb_c,
    output logic                             valid_out,
    output types_pkg::rs_data                data_out,
    input  logic                             fu_rdy
);
    import types_pkg::*;

    localparam int IDX_W = (`RS_DEPTH > 1) ? $clog2(`RS_DEPTH) : 1;

    logic                  entry_valid [`RS_DEPTH];
    dispatch_pipeline_data entry       [`RS_DEPTH];
    logic [IDX_W-1:0]      entry_age   [`RS_DEPTH];

    logic [`RS_DEPTH-1:0] entry_ready;
    logic [`RS_DEPTH-1:0] age_drop;
    logic                 free_found;
    logic [IDX_W-1:0]     free_idx;
    logic                 sel_found;
    logic [IDX_W-1:0]     sel_idx;
    logic                 write_en;
    logic                 issue_en;

    // Lowest free slot
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    // Oldest ready entry, largest age wins
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            entry_ready[i] = entry_valid[i] && entry[i].pr1_ready && entry[i].pr2_ready;
            if (entry_ready[i] && (!sel_found || entry_age[i] > entry_age[sel_idx])) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    // Entries older than the issued one lose a younger neighbour
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            age_drop[i] = issue_en && entry_valid[i] && (entry_age[i] > entry_age[sel_idx]);
        end
    end

    assign ready_in  = free_found;
    assign valid_out = sel_found;
    assign write_en  = valid_in && free_found;
    assign issue_en  = sel_found && fu_rdy;

    always_comb begin
        data_out.opcode    = entry[sel_idx].opcode;
        data_out.func3     = entry[sel_idx].func3;
        data_out.func7     = entry[sel_idx].func7;
        data_out.pc        = entry[sel_idx].pc;
        data_out.imm       = entry[sel_idx].imm;
        data_out.prd       = entry[sel_idx].prd;
        data_out.pr1       = entry[sel_idx].pr1;
        data_out.pr2       = entry[sel_idx].pr2;
        data_out.rob_index = entry[sel_idx].rob_index;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                entry_valid[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (entry_valid[i]) begin
                    // Wakeup
                    if (cdb_match(entry[i].pr1, cdb_a, cdb_b, cdb_c)) begin
                        entry[i].pr1_ready <= 1'b1;
                    end
                    if (cdb_match(entry[i].pr2, cdb_a, cdb_b, cdb_c)) begin
                        entry[i].pr2_ready <= 1'b1;
                    end
                    // Age counts the younger entries
                    if (write_en && !age_drop[i]) begin
                        entry_age[i] <= entry_age[i] + 1'b1;
                    end else if (!write_en && age_drop[i]) begin
                        entry_age[i] <= entry_age[i] - 1'b1;
                    end
                end
            end
            if (issue_en) begin
                entry_valid[sel_idx] <= 1'b0;
            end
            if (write_en) begin
                entry_valid[free_idx] <= 1'b1;
                entry[free_idx]       <= instr;
                entry_age[free_idx]   <= '0;
            end
        end
    end

    // Dispatch must hold its drain until a slot is free
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (reset)
        valid_in |-> ready_in
    ) else $error("write into a full reservation station");

endmodule

//--- verilog/ready_table.sv
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module ready_table (
    input  logic               clk,
    input  logic               reset,
    input  logic               busy_valid,
    input  logic [`PREG_W-1:0] busy_preg,
    input  types_pkg::cdb_t    cdb_a,
    input  types_pkg::cdb_t    cdb_b,
    input  types_pkg::cdb_t    cdb_c,
    input  logic [`PREG_W-1:0] query_ps1,
    input  logic [`PREG_W-1:0] query_ps2,
    output logic               pr1_ready,
    output logic               pr2_ready
);

    logic [`PREG_COUNT-1:0] ready_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q <= '1;
        end else begin
            if (busy_valid) begin
                ready_q[busy_preg] <= 1'b0;
            end
            // Broadcasts come later so they override a same-cycle busy-set
            if (cdb_a.valid) begin
                ready_q[cdb_a.preg] <= 1'b1;
            end
            if (cdb_b.valid) begin
                ready_q[cdb_b.preg] <= 1'b1;
            end
            if (cdb_c.valid) begin
                ready_q[cdb_c.preg] <= 1'b1;
            end
            ready_q[0] <= 1'b1;
        end
    end

    assign pr1_ready = ready_q[query_ps1];
    assign pr2_ready = ready_q[query_ps2];

    // x0 never gets a new mapping from rename
    a_no_busy_x0: assert property (
        @(posedge clk) disable iff (reset)
        busy_valid |-> (busy_preg != '0)
    ) else $error("register 0 marked busy");

endmodule

//--- verilog/skid_buffer_struct.sv
`timescale 1ns/1ps

module skid_buffer_struct #(
    parameter type T = logic [7:0]
) (
    input  logic clk,
    input  logic reset,
    input  logic mispredict,
    input  logic valid_in,
    output logic ready_in,
    input  T     data_in,
    output logic valid_out,
    input  logic ready_out,
    output T     data_out
);

    T     main_data;
    T     skid_data;
    logic main_valid;
    logic skid_valid;
    logic rdy_q;
    logic accept;
    logic pop;

    assign accept    = valid_in && rdy_q;
    assign pop       = main_valid && ready_out;
    assign ready_in  = rdy_q;
    assign valid_out = main_valid;
    assign data_out  = main_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            rdy_q      <= 1'b0;
        end else if (mispredict) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            rdy_q      <= 1'b1;
        end else if (!main_valid || pop) begin
            // Skid entry moves up first
            main_valid <= skid_valid || accept;
            skid_valid <= 1'b0;
            rdy_q      <= 1'b1;
        end else if (accept) begin
            skid_valid <= 1'b1;
            rdy_q      <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!main_valid || pop) begin
            main_data <= skid_valid ? skid_data : data_in;
        end
        if (accept && main_valid && !pop) begin
            skid_data <= data_in;
        end
    end

    // Registered ready must already be low once both slots hold data
    a_no_accept_when_full: assert property (
        @(posedge clk) disable iff (reset)
        (main_valid && skid_valid) |-> !accept
    ) else $error("skid buffer accepted data while full");

endmodule

//--- verilog/types_pkg.sv
`include "dispatch_settings.svh"

package types_pkg;

    // One-hot functional unit class
    typedef struct packed {
        logic mem;
        logic br;
        logic alu;
    } fu_class_t;

    // Packet from rename
    typedef struct packed {
        logic [6:0]         opcode;
        logic [2:0]         func3;
        logic [6:0]         func7;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   imm;
        logic [`PREG_W-1:0] ps1;
        logic [`PREG_W-1:0] ps2;
        logic [`PREG_W-1:0] pd_new;
        logic [`PREG_W-1:0] pd_old;
        fu_class_t          fu;
    } rename_data;

    // Packet written into a station
    typedef struct packed {
        logic [6:0]            opcode;
        logic [2:0]            func3;
        logic [6:0]            func7;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      imm;
        logic [`PREG_W-1:0]    prd;
        logic [`PREG_W-1:0]    pr1;
        logic [`PREG_W-1:0]    pr2;
        logic                  pr1_ready;
        logic                  pr2_ready;
        logic [`ROB_TAG_W-1:0] rob_index;
    } dispatch_pipeline_data;

    // Issued to a functional unit
    typedef struct packed {
        logic [6:0]            opcode;
        logic [2:0]            func3;
        logic [6:0]            func7;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      imm;
        logic [`PREG_W-1:0]    prd;
        logic [`PREG_W-1:0]    pr1;
        logic [`PREG_W-1:0]    pr2;
        logic [`ROB_TAG_W-1:0] rob_index;
    } rs_data;

    typedef struct packed {
        logic               valid;
        logic [`PREG_W-1:0] preg;
    } cdb_t;

    typedef struct packed {
        logic               we;
        logic [`PREG_W-1:0] pd_new;
        logic [`PREG_W-1:0] pd_old;
        logic [`XLEN-1:0]   pc;
    } rob_alloc_t;

    // Tag seen on any of the three result broadcasts
    function automatic logic cdb_match(
        input logic [`PREG_W-1:0] tag,
        input cdb_t               a,
        input cdb_t               b,
        input cdb_t               c
    );
        cdb_match = (a.valid && a.preg == tag) ||
                    (b.valid && b.preg == tag) ||
                    (c.valid && c.preg == tag);
    endfunction

endpackage

//--- verilog/dispatch_settings.svh
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// Physical register file
`define PREG_W     7
`define PREG_COUNT 128

// ROB tag width
`define ROB_TAG_W  5

// Entries per reservation station
`define RS_DEPTH   4

`define XLEN       32

`endif
